/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --timescale 1ns/1ps
TOP       = intt_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
PASS_MSG  = ALL TESTS PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the simulation passes only if the pass line shows up in its output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* files.f */
+incdir+hdl
+incdir+verification
hdl/intt_ctrl_pkg.sv
hdl/intt_data_pkg.sv
hdl/coef_ram.sv
hdl/mod_butterfly.sv
hdl/intt_addr_gen.sv
hdl/intt_sequencer.sv
hdl/intt_core.sv
verification/intt_tb.sv

/* hdl/coef_ram.sv */
// dual port coefficient memory
`timescale 1ns/1ps
`include "intt_cfg.svh"

module coef_ram
    import intt_data_pkg::*;
#(
    parameter int DEPTH = `RING_SIZE
) (
    input  logic    clk,
    input  ram_wr_t wr0,
    input  ram_wr_t wr1,
    input  addr_t   raddr0,
    input  addr_t   raddr1,
    output coef_t   rdata0,
    output coef_t   rdata1
);

    localparam int AW = $clog2(DEPTH);

    coef_t mem [DEPTH];

    // the two write ports never hit the same word in one cycle
    always_ff @(posedge clk) begin
        if (wr0.en) begin
            mem[wr0.addr[AW-1:0]] <= wr0.data;
        end
        if (wr1.en) begin
            mem[wr1.addr[AW-1:0]] <= wr1.data;
        end
        rdata0 <= mem[raddr0[AW-1:0]];  // read before write
        rdata1 <= mem[raddr1[AW-1:0]];
    end

endmodule

/* hdl/intt_addr_gen.sv */
// butterfly address schedule
`timescale 1ns/1ps
`include "intt_cfg.svh"

module intt_addr_gen
    import intt_ctrl_pkg::*;
    import intt_data_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  seq_state_t state,
    input  logic       sched_start,
    output logic       sched_done,
    output addr_t      raddr0,
    output addr_t      raddr1,
    output tw_addr_t   tw_raddr,
    output logic       issue_valid,
    output bfly_op_t   issue_op,
    output addr_t      waddr0,
    output addr_t      waddr1
);

    localparam int PAIRS    = `RING_SIZE / 2;
    localparam int WB_DELAY = 1 + `BFLY_LATENCY;  // memory read plus butterfly
    localparam int STAGE_W  = $clog2(`RING_DEPTH + 1);
    localparam int SLOT_W   = $clog2(`STAGE_SLOTS);

    logic               active;
    logic [STAGE_W-1:0] stage;  // RING_DEPTH means the scale pass
    logic [SLOT_W-1:0]  slot;
    logic               run, issue, scale_pass;
    addr_t              pair, low_mask;
    addr_t              wa0_pipe [WB_DELAY];
    addr_t              wa1_pipe [WB_DELAY];

    assign run        = (state == st_transform) || (state == st_scale);
    assign scale_pass = (stage == STAGE_W'(`RING_DEPTH));
    assign issue      = active && (slot < SLOT_W'(PAIRS));
    assign sched_done = active && scale_pass && (slot == SLOT_W'(`STAGE_SLOTS - 1));
    assign pair       = addr_t'(slot[`RING_DEPTH-2:0]);

    // pair j of group g: g*2h + j and g*2h + j + h, twiddle j*N/(2h)
    always_comb begin
        low_mask = addr_t'((1 << stage) - 1);
        if (scale_pass) begin
            raddr0   = pair;
            raddr1   = pair | addr_t'(PAIRS);
            tw_raddr = '0;
        end else begin
            raddr0   = ((pair & ~low_mask) << 1) | (pair & low_mask);
            raddr1   = raddr0 | addr_t'(1 << stage);
            tw_raddr = tw_addr_t'((pair & low_mask) << (`RING_DEPTH - 1 - stage));
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            active <= 1'b0;
            stage  <= '0;
            slot   <= '0;
        end else if (!run) begin
            active <= 1'b0;
            stage  <= '0;
            slot   <= '0;
        end else if (sched_start) begin
            active <= 1'b1;
            stage  <= '0;
            slot   <= '0;
        end else if (active) begin
            if (slot == SLOT_W'(`STAGE_SLOTS - 1)) begin  // drain gap over
                slot <= '0;
                if (scale_pass) begin
                    active <= 1'b0;
                end else begin
                    stage <= stage + 1'b1;
                end
            end else begin
                slot <= slot + 1'b1;
            end
        end
    end

    // lines up with the registered ram read
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            issue_valid <= 1'b0;
            issue_op    <= op_ct;
        end else begin
            issue_valid <= issue;
            issue_op    <= scale_pass ? op_scale : op_ct;
        end
    end

    always_ff @(posedge clk) begin
        wa0_pipe[0] <= raddr0;
        wa1_pipe[0] <= raddr1;
        for (int i = 1; i < WB_DELAY; i++) begin
            wa0_pipe[i] <= wa0_pipe[i-1];
            wa1_pipe[i] <= wa1_pipe[i-1];
        end
    end

    assign waddr0 = wa0_pipe[WB_DELAY-1];
    assign waddr1 = wa1_pipe[WB_DELAY-1];

endmodule

/* hdl/intt_cfg.svh */
// intt engine configuration
`ifndef INTT_CFG_SVH
`define INTT_CFG_SVH

// ring geometry
`define RING_DEPTH 4
`define RING_SIZE (1 << `RING_DEPTH)

// residue and modulus width
`define DATA_WIDTH 16

// multiply, reduce, add-subtract
`define BFLY_LATENCY 3

// inverse twiddles stored, one per butterfly index
`define TW_COUNT (`RING_SIZE / 2)

// cycles per stage: N/2 issue slots plus the drain gap
`define STAGE_SLOTS (`RING_SIZE / 2 + 1 + `BFLY_LATENCY)

`endif

/* hdl/intt_core.sv */
// single butterfly intt engine
`timescale 1ns/1ps
`include "intt_cfg.svh"

module intt_core
    import intt_ctrl_pkg::*;
    import intt_data_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  load_w,
    input  logic  load_data,
    input  logic  start_intt,
    input  coef_t din,
    output logic  done,
    output coef_t dout,
    output logic  dout_valid,
    output logic  busy
);

    seq_state_t state;
    logic       sched_start, sched_done;
    coef_t      q, n_inv;
    ram_wr_t    data_wr0, data_wr1, tw_wr;
    ram_wr_t    bfly_wr0, bfly_wr1;
    addr_t      out_raddr, ram_raddr0;
    addr_t      gen_raddr0, gen_raddr1, gen_waddr0, gen_waddr1;
    tw_addr_t   tw_raddr;
    logic       issue_valid;
    bfly_op_t   issue_op;
    coef_t      rd_data0, rd_data1, tw_rdata;
    bfly_in_t   bfly_in;
    bfly_out_t  bfly_out;

    assign ram_raddr0 = (state == st_output) ? out_raddr : gen_raddr0;

    // scale pass takes n_inv in place of the twiddle
    assign bfly_in = '{valid: issue_valid, op: issue_op, a: rd_data0, b: rd_data1,
                       w: (issue_op == op_scale) ? n_inv : tw_rdata};

    assign bfly_wr0 = '{en: bfly_out.valid, addr: gen_waddr0, data: bfly_out.a};
    assign bfly_wr1 = '{en: bfly_out.valid, addr: gen_waddr1, data: bfly_out.b};

    intt_sequencer seq_i (
        .clk, .reset, .load_w, .load_data, .start_intt, .din,
        .sched_done, .bfly_wr0, .bfly_wr1, .rd_data0,
        .state, .sched_start, .q, .n_inv,
        .data_wr0, .data_wr1, .tw_wr, .out_raddr,
        .done, .dout, .dout_valid, .busy
    );

    intt_addr_gen agen_i (
        .clk, .reset, .state, .sched_start, .sched_done,
        .raddr0(gen_raddr0), .raddr1(gen_raddr1), .tw_raddr,
        .issue_valid, .issue_op,
        .waddr0(gen_waddr0), .waddr1(gen_waddr1)
    );

    mod_butterfly bfly_i (
        .clk, .reset, .q, .bfly_in, .bfly_out
    );

    coef_ram #(.DEPTH(`RING_SIZE)) data_ram (
        .clk, .wr0(data_wr0), .wr1(data_wr1),
        .raddr0(ram_raddr0), .raddr1(gen_raddr1),
        .rdata0(rd_data0), .rdata1(rd_data1)
    );

    coef_ram #(.DEPTH(`TW_COUNT)) tw_ram (  // single write, single read
        .clk, .wr0(tw_wr), .wr1('0),
        .raddr0({1'b0, tw_raddr}), .raddr1('0),
        .rdata0(tw_rdata), .rdata1()
    );

endmodule

/* hdl/intt_ctrl_pkg.sv */
// intt control encodings
package intt_ctrl_pkg;

    // top sequencer states
    typedef enum logic [2:0] {
        st_idle      = 3'd0,
        st_load_tw   = 3'd1,  // twiddles, then q, then n_inv
        st_load_data = 3'd2,  // coefficients, natural order in
        st_transform = 3'd3,
        st_scale     = 3'd4,  // multiply by n_inv
        st_output    = 3'd5
    } seq_state_t;

    // butterfly operation
    typedef enum logic {
        op_ct    = 1'b0,  // a + b*w, a - b*w
        op_scale = 1'b1   // a*w, b*w
    } bfly_op_t;

endpackage

/* hdl/intt_data_pkg.sv */
// intt datapath types
`include "intt_cfg.svh"

package intt_data_pkg;

    import intt_ctrl_pkg::*;

    typedef logic [`DATA_WIDTH-1:0] coef_t;
    typedef logic [`RING_DEPTH-1:0] addr_t;
    typedef logic [`RING_DEPTH-2:0] tw_addr_t;

    // one memory write port
    typedef struct packed {
        logic  en;
        addr_t addr;
        coef_t data;
    } ram_wr_t;

    // butterfly operands
    typedef struct packed {
        logic     valid;
        bfly_op_t op;
        coef_t    a;
        coef_t    b;
        coef_t    w;  // twiddle or n_inv
    } bfly_in_t;

    typedef struct packed {
        logic  valid;
        coef_t a;
        coef_t b;
    } bfly_out_t;

endpackage

/* hdl/intt_sequencer.sv */
// intt top sequencer
`timescale 1ns/1ps
`include "intt_cfg.svh"

module intt_sequencer
    import intt_ctrl_pkg::*;
    import intt_data_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic       load_w,
    input  logic       load_data,
    input  logic       start_intt,
    input  coef_t      din,
    input  logic       sched_done,
    input  ram_wr_t    bfly_wr0,
    input  ram_wr_t    bfly_wr1,
    input  coef_t      rd_data0,
    output seq_state_t state,
    output logic       sched_start,
    output coef_t      q,
    output coef_t      n_inv,
    output ram_wr_t    data_wr0,
    output ram_wr_t    data_wr1,
    output ram_wr_t    tw_wr,
    output addr_t      out_raddr,
    output logic       done,
    output coef_t      dout,
    output logic       dout_valid,
    output logic       busy
);

    localparam int CNT_W = $clog2((`RING_DEPTH + 1) * `STAGE_SLOTS + 1);

    localparam logic [CNT_W-1:0] Q_SLOT    = CNT_W'(`TW_COUNT);
    localparam logic [CNT_W-1:0] TW_LAST   = CNT_W'(`TW_COUNT + 1);  // n_inv slot
    localparam logic [CNT_W-1:0] DATA_LAST = CNT_W'(`RING_SIZE - 1);
    localparam logic [CNT_W-1:0] RUN_LAST  = CNT_W'(`RING_DEPTH * `STAGE_SLOTS);
    localparam logic [CNT_W-1:0] OUT_READS = CNT_W'(`RING_SIZE);
    localparam logic [CNT_W-1:0] OUT_LAST  = CNT_W'(`RING_SIZE + 1);

    logic [CNT_W-1:0] cnt;
    logic             rd_pending;  // read issued last cycle
    addr_t            load_addr;

    always_comb begin
        for (int i = 0; i < `RING_DEPTH; i++) begin
            load_addr[i] = cnt[`RING_DEPTH-1-i];  // bit reversed
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state       <= st_idle;
            cnt         <= '0;
            sched_start <= 1'b0;
        end else begin
            sched_start <= 1'b0;
            cnt         <= cnt + 1'b1;
            case (state)
                st_idle: begin
                    cnt <= '0;
                    if (load_w) begin
                        state <= st_load_tw;
                    end else if (load_data) begin
                        state <= st_load_data;
                    end else if (start_intt) begin
                        state       <= st_transform;
                        sched_start <= 1'b1;
                    end
                end
                st_load_tw:   if (cnt == TW_LAST) state <= st_idle;
                st_load_data: if (cnt == DATA_LAST) state <= st_idle;
                st_transform: if (cnt == RUN_LAST) state <= st_scale;  // generator enters scale pass
                st_scale: begin
                    if (sched_done) begin
                        state <= st_output;
                        cnt   <= '0;
                    end
                end
                st_output:    if (cnt == OUT_LAST) state <= st_idle;
                default:      state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            q     <= '0;
            n_inv <= '0;
        end else if (state == st_load_tw) begin
            if (cnt == Q_SLOT) q <= din;
            if (cnt == TW_LAST) n_inv <= din;
        end
    end

    // write arbitration between load and butterfly write-back
    always_comb begin
        data_wr0 = '0;
        data_wr1 = '0;
        tw_wr    = '0;
        case (state)
            st_load_tw: begin
                if (cnt < Q_SLOT) begin
                    tw_wr = '{en: 1'b1, addr: {1'b0, cnt[`RING_DEPTH-2:0]}, data: din};
                end
            end
            st_load_data: data_wr0 = '{en: 1'b1, addr: load_addr, data: din};
            st_transform, st_scale: begin
                data_wr0 = bfly_wr0;
                data_wr1 = bfly_wr1;
            end
            default: ;
        endcase
    end

    assign out_raddr = cnt[`RING_DEPTH-1:0];
    assign busy      = (state != st_idle);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            done       <= 1'b0;
            rd_pending <= 1'b0;
            dout_valid <= 1'b0;
            dout       <= '0;
        end else begin
            done       <= (state == st_output) && (cnt == '0);
            rd_pending <= (state == st_output) && (cnt < OUT_READS);
            dout_valid <= rd_pending;
            dout       <= rd_pending ? rd_data0 : '0;
        end
    end

endmodule

/* hdl/mod_butterfly.sv */
// pipelined modular butterfly
`timescale 1ns/1ps
`include "intt_cfg.svh"

module mod_butterfly
    import intt_ctrl_pkg::*;
    import intt_data_pkg::*;
(
    input  logic      clk,
    input  logic      reset,
    input  coef_t     q,
    input  bfly_in_t  bfly_in,
    output bfly_out_t bfly_out
);

    localparam int W  = `DATA_WIDTH;
    localparam int PW = 2 * `DATA_WIDTH;

    logic           s1_valid, s2_valid, s3_valid;
    bfly_op_t       s1_op, s2_op;
    logic [PW-1:0]  s1_pa, s1_pb;
    coef_t          s2_ra, s2_rb;
    coef_t          s3_a, s3_b;
    logic [W:0]     sum, diff;
    coef_t          sum_mod, diff_mod;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
            s3_valid <= 1'b0;
        end else begin
            s1_valid <= bfly_in.valid;
            s2_valid <= s1_valid;
            s3_valid <= s2_valid;
        end
    end

    // in ct mode a rides through the multiplier untouched, so the reduce is a no-op
    always_ff @(posedge clk) begin
        s1_op <= bfly_in.op;
        s1_pb <= PW'(bfly_in.b) * PW'(bfly_in.w);
        s1_pa <= (bfly_in.op == op_scale) ? PW'(bfly_in.a) * PW'(bfly_in.w) : PW'(bfly_in.a);
        s2_op <= s1_op;
        s2_ra <= coef_t'(s1_pa % PW'(q));
        s2_rb <= coef_t'(s1_pb % PW'(q));
        s3_a  <= (s2_op == op_scale) ? s2_ra : sum_mod;
        s3_b  <= (s2_op == op_scale) ? s2_rb : diff_mod;
    end

    always_comb begin
        sum      = {1'b0, s2_ra} + {1'b0, s2_rb};
        diff     = {1'b0, s2_ra} + {1'b0, q} - {1'b0, s2_rb};  // stays positive
        sum_mod  = (sum >= {1'b0, q}) ? coef_t'(sum - {1'b0, q}) : coef_t'(sum);
        diff_mod = (diff >= {1'b0, q}) ? coef_t'(diff - {1'b0, q}) : coef_t'(diff);
    end

    assign bfly_out = '{valid: s3_valid, a: s3_a, b: s3_b};

endmodule

/* verification/intt_ref_model.svh */
// inverse ntt reference model
`ifndef INTT_REF_MODEL_SVH
`define INTT_REF_MODEL_SVH

function automatic int unsigned mul_mod(input int unsigned a, input int unsigned b,
                                        input int unsigned q);
    longint unsigned prod;
    prod = {32'd0, a} * {32'd0, b};
    return 32'(prod % {32'd0, q});
endfunction

// square and multiply
function automatic int unsigned pow_mod(input int unsigned base, input int unsigned e,
                                        input int unsigned q);
    int unsigned result;
    int unsigned b;
    int unsigned k;
    result = 1 % q;
    b      = base % q;
    k      = e;
    while (k != 0) begin
        if (k[0]) result = mul_mod(result, b, q);
        b = mul_mod(b, b, q);
        k = k >> 1;
    end
    return result;
endfunction

function automatic int unsigned inv_mod(input int unsigned a, input int unsigned q);
    return pow_mod(a, q - 2, q);  // fermat, q prime
endfunction

// order exactly N since N is a power of two
function automatic int unsigned find_root(input int unsigned q);
    int unsigned root;
    root = 0;
    for (int unsigned g = 2; g < q && root == 0; g++) begin
        if (pow_mod(g, `RING_SIZE, q) == 1 && pow_mod(g, `RING_SIZE / 2, q) != 1) begin
            root = g;
        end
    end
    return root;
endfunction

function automatic int unsigned twiddle_at(input int unsigned w_inv, input int j,
                                           input int unsigned q);
    return pow_mod(w_inv, j, q);
endfunction

// X[i] = n_inv * sum x[j] * w^-ij
function automatic int unsigned inverse_coef(input int unsigned x [`RING_SIZE], input int i,
                                             input int unsigned q, input int unsigned w_inv,
                                             input int unsigned n_inv);
    int unsigned acc;
    int unsigned e;
    acc = 0;
    for (int j = 0; j < `RING_SIZE; j++) begin
        e   = (i * j) % `RING_SIZE;
        acc = (acc + mul_mod(x[j], pow_mod(w_inv, e, q), q)) % q;
    end
    return mul_mod(acc, n_inv, q);
endfunction

`endif

/* verification/intt_tb.sv */
// intt engine testbench
`timescale 1ns/1ps
`include "intt_cfg.svh"

module intt_tb
    import intt_data_pkg::*;
();

    localparam int N            = `RING_SIZE;
    localparam int DONE_TIMEOUT = 200;  // cycles from start to done
    localparam int IDLE_TIMEOUT = 50;

    logic  clk;
    logic  reset;
    logic  load_w;
    logic  load_data;
    logic  start_intt;
    coef_t din;
    logic  done;
    coef_t dout;
    logic  dout_valid;
    logic  busy;

    int unsigned cur_q, cur_w_inv, cur_n_inv;
    int unsigned coefs    [N];
    int unsigned expected [N];

    `include "intt_ref_model.svh"

    intt_core dut_i (
        .clk, .reset, .load_w, .load_data, .start_intt, .din,
        .done, .dout, .dout_valid, .busy
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic halt_with_failure(input string what);
        $display("%s", what);
        $display("SOME TESTS FAILED");
        $fatal(1, "stopped at the first failure");
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] want);
        assert (got === want)
            else halt_with_failure($sformatf("error: %s = %h, expected %h", name, got, want));
    endtask

    task automatic wait_idle(input string what);
        int waited;
        waited = 0;
        @(negedge clk);
        while (busy) begin
            assert (waited < IDLE_TIMEOUT)
                else halt_with_failure({"timeout: engine stayed busy after ", what});
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic select_modulus(input int unsigned q);
        int unsigned w;
        cur_q     = q;
        w         = find_root(q);
        cur_w_inv = inv_mod(w, q);
        cur_n_inv = inv_mod(N, q);
    endtask

    // twiddles, then q, then n_inv on consecutive cycles
    task automatic load_twiddles();
        @(posedge clk);
        load_w <= 1'b1;
        for (int j = 0; j < `TW_COUNT; j++) begin
            @(posedge clk);
            load_w <= 1'b0;
            din    <= coef_t'(twiddle_at(cur_w_inv, j, cur_q));
        end
        @(posedge clk);
        din <= coef_t'(cur_q);
        @(posedge clk);
        din <= coef_t'(cur_n_inv);
        @(posedge clk);
        din <= '0;
        wait_idle("the twiddle load");
    endtask

    task automatic load_coefs();
        @(posedge clk);
        load_data <= 1'b1;
        for (int j = 0; j < N; j++) begin
            @(posedge clk);
            load_data <= 1'b0;
            din       <= coef_t'(coefs[j]);
        end
        @(posedge clk);
        din <= '0;
        wait_idle("the data load");
    endtask

    function automatic void fill_random();
        for (int j = 0; j < N; j++) begin
            coefs[j] = $urandom % cur_q;
        end
    endfunction

    function automatic void compute_expected();
        for (int i = 0; i < N; i++) begin
            expected[i] = inverse_coef(coefs, i, cur_q, cur_w_inv, cur_n_inv);
        end
    endfunction

    // start, optionally pulse stray commands, then check done and the output burst
    task automatic run_transform(input bit disturb);
        int waited;
        @(posedge clk);
        start_intt <= 1'b1;
        @(posedge clk);
        start_intt <= 1'b0;
        if (disturb) begin
            repeat (3) @(posedge clk);
            load_data <= 1'b1;
            din       <= coef_t'($urandom);
            @(posedge clk);
            load_data <= 1'b0;
            repeat (20) @(posedge clk);
            load_w <= 1'b1;
            din    <= coef_t'($urandom);
            @(posedge clk);
            load_w <= 1'b0;
            din    <= '0;
        end
        waited = 0;
        @(negedge clk);
        while (!done) begin
            assert (waited < DONE_TIMEOUT)
                else halt_with_failure("timeout: no done pulse after start");
            expect_eq("dout_valid", 32'(dout_valid), 0);
            expect_eq("busy", 32'(busy), 1);
            @(negedge clk);
            waited++;
        end
        for (int i = 0; i < N; i++) begin
            @(negedge clk);
            expect_eq("done", 32'(done), 0);  // single cycle pulse
            expect_eq("dout_valid", 32'(dout_valid), 1);
            expect_eq($sformatf("dout[%0d]", i), 32'(dout), expected[i]);
        end
        @(negedge clk);
        expect_eq("dout_valid", 32'(dout_valid), 0);
        expect_eq("busy", 32'(busy), 0);
    endtask

    initial begin
        void'($urandom(95));
        reset      = 1'b1;
        load_w     = 1'b0;
        load_data  = 1'b0;
        start_intt = 1'b0;
        din        = '0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        expect_eq("done", 32'(done), 0);
        expect_eq("dout_valid", 32'(dout_valid), 0);
        expect_eq("busy", 32'(busy), 0);
        expect_eq("dout", 32'(dout), 0);

        select_modulus(97);
        load_twiddles();
        fill_random();
        load_coefs();
        compute_expected();
        run_transform(1'b0);

        // impulse at x[0]
        for (int j = 0; j < N; j++) begin
            coefs[j]    = 0;
            expected[j] = cur_n_inv;
        end
        coefs[0] = 1;
        load_coefs();
        run_transform(1'b0);

        coefs = expected;  // memory now holds the last result
        compute_expected();
        run_transform(1'b0);

        select_modulus(7681);
        load_twiddles();
        fill_random();
        load_coefs();
        compute_expected();
        run_transform(1'b0);

        fill_random();
        load_coefs();
        compute_expected();
        run_transform(1'b1);  // stray load pulses while running

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule
